// ==== design/muladd_config_pkg.sv ====
`default_nettype none

// configuration word and the records passed between stages
package muladd_config_pkg;

   import muladd_types_pkg::*;

   // operation codes, op_macc is also the catch-all
   typedef enum logic [3:0] {
      op_macc         = 4'd0,
      op_mul_div2     = 4'd1,
      op_mul          = 4'd2,
      op_macc_div2    = 4'd3,
      op_msub_div2    = 4'd4,
      op_macc_hi      = 4'd5,
      op_macc_16q16   = 4'd6,
      op_msub         = 4'd7,
      op_mul_low      = 4'd8,
      op_mul_low_macc = 4'd9
   } muladd_op_e;

   // static configuration, sela in the top bits
   typedef struct packed {
      sel_t       sela;   // multiplicand
      sel_t       selb;   // multiplier
      sel_t       selo;   // control word, zero restarts the accumulator
      muladd_op_e opcode;
   } muladd_cfg_t;

   // decode to execute
   // ld_acc already lags op_a/op_b by one cycle
   typedef struct packed {
      data_t op_a;
      data_t op_b;
      logic  ld_acc;
   } operands_t;

   // execute to result, product and flag from the same sample
   typedef struct packed {
      prod_t product;
      logic  ld_acc;
   } product_t;

endpackage

`default_nettype wire

// ==== design/muladd_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

// splits the configuration word and picks operands off the flow bus
module muladd_decode
   import muladd_types_pkg::*, muladd_config_pkg::*;
#(
   parameter int n_flow = 8
) (
   input  wire logic                     clk,
   input  wire logic                     rst,
   input  wire muladd_cfg_t              cfg,
   input  wire data_t [n_flow-1:0]       flow_in,
   output operands_t                     opnds,
   output muladd_op_e                    opcode
);

   // bus word behind a select, zero for an index past the bus
   function automatic data_t pick_word(input sel_t sel, input data_t [n_flow-1:0] words);
      if (int'(sel) < n_flow) begin
         return words[sel];
      end
      return '0;
   endfunction

   data_t op_o;       // control word chosen by selo
   logic  ld_acc_q;   // selo word was zero last cycle

   assign opcode = cfg.opcode;

   // operand muxes, no latency
   assign opnds.op_a = pick_word(cfg.sela, flow_in);
   assign opnds.op_b = pick_word(cfg.selb, flow_in);
   assign op_o       = pick_word(cfg.selo, flow_in);

   // flag lines up with the operand registers in execute
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ld_acc_q <= 1'b0;
      end else begin
         ld_acc_q <= (op_o == '0);
      end
   end

   assign opnds.ld_acc = ld_acc_q;

   // every select must name a word that exists on this bus
   sel_range_a: assert property (
      @(posedge clk) disable iff (rst)
         (int'(cfg.sela) < n_flow) &&
         (int'(cfg.selb) < n_flow) &&
         (int'(cfg.selo) < n_flow)
   ) else $error("muladd_decode: select out of range, cfg %h, n_flow %0d", cfg, n_flow);

endmodule

`default_nettype wire

// ==== design/muladd_execute.sv ====
`timescale 1ns/1ns
`default_nettype none

// two-stage signed 32x32 multiplier
module muladd_execute
   import muladd_types_pkg::*, muladd_config_pkg::*;
(
   input  wire logic      clk,
   input  wire logic      rst,
   input  wire operands_t opnds,
   output product_t       prod
);

   data_t a_q;   // stage 1 operands
   data_t b_q;
   logic signed [2*data_w-1:0] mul_full;   // full width signed product
   product_t prod_q;                      // stage 2

   assign mul_full = $signed(a_q) * $signed(b_q);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         a_q    <= '0;
         b_q    <= '0;
         prod_q <= '0;
      end else begin
         a_q <= opnds.op_a;
         b_q <= opnds.op_b;

         // flag arrives a cycle late from decode, so it joins here
         prod_q.product <= prod_t'(mul_full);
         prod_q.ld_acc  <= opnds.ld_acc;
      end
   end

   assign prod = prod_q;

   // both stages come out of reset empty, so the first two products are zero
   prod_flush_a: assert property (
      @(posedge clk)
         $fell(rst) |-> (prod == '0) ##1 (prod == '0)
   ) else $error("muladd_execute: product not cleared after reset, prod %h", prod);

endmodule

`default_nettype wire

// ==== design/muladd_result.sv ====
`timescale 1ns/1ns
`default_nettype none

// shapes the product per opcode and holds the accumulator
module muladd_result
   import muladd_types_pkg::*, muladd_config_pkg::*;
(
   input  wire logic       clk,
   input  wire logic       rst,
   input  wire product_t   prod,
   input  wire muladd_op_e opcode,
   output data_t          flow_out
);

   // keeps the upper word only
   localparam prod_t hi_mask = {{data_w{1'b1}}, {data_w{1'b0}}};

   prod_t acc;
   prod_t shaped;   // next accumulator value

   prod_t p;        // raw product
   prod_t p_x2;     // q1.31 times q1.31 realigned
   prod_t p_lo;     // low word moved up
   prod_t p_q16;    // 16q16 product in upper word
   logic  restart;

   assign p       = prod.product;
   assign p_x2    = p << 1;
   assign p_lo    = p << data_w;
   assign p_q16   = {p[3*data_w/2-1 -: data_w], {data_w{1'b0}}};
   assign restart = prod.ld_acc;

   always_comb begin
      case (opcode)
         op_mul_div2: shaped = p & hi_mask;
         op_mul:      shaped = p_x2;
         op_mul_low:  shaped = p_lo;

         op_macc_div2: begin
            if (restart) begin
               shaped = p & hi_mask;
            end else begin
               shaped = (acc + p) & hi_mask;
            end
         end

         op_msub_div2: begin
            if (restart) begin
               shaped = p;
            end else begin
               shaped = acc - p;
            end
         end

         op_macc_hi: begin
            if (restart) begin
               shaped = p_x2 & hi_mask;
            end else begin
               shaped = (acc + p_x2) & hi_mask;
            end
         end

         op_macc_16q16: begin
            if (restart) begin
               shaped = p_q16;
            end else begin
               shaped = acc + p_q16;
            end
         end

         op_msub: begin
            if (restart) begin
               shaped = p_x2;
            end else begin
               shaped = acc - p_x2;
            end
         end

         op_mul_low_macc: shaped = acc + p_lo;   // no restart here

         default: begin   // op_macc
            if (restart) begin
               shaped = p_x2;
            end else begin
               shaped = acc + p_x2;
            end
         end
      endcase
   end

   // acc follows the shaped value every cycle, plain multiplies too
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         acc <= '0;
      end else begin
         acc <= shaped;
      end
   end

   assign flow_out = shaped[2*data_w-1 -: data_w];

   // an undriven config word would poison acc for good
   opcode_known_a: assert property (
      @(posedge clk) disable iff (rst)
         !$isunknown(opcode)
   ) else $error("muladd_result: opcode unknown");

endmodule

`default_nettype wire

// ==== design/muladd_types_pkg.sv ====
`default_nettype none

// widths shared by every stage of the multiply-accumulate unit
package muladd_types_pkg;

   // flow bus word, fixed point positions in result depend on it
   localparam int data_w = 32;

   // select field, enough for 16 bus words
   localparam int sel_w = 4;

   // one word of the data flow bus
   typedef logic [data_w-1:0] data_t;

   // full signed product, accumulator or shaped result
   typedef logic [2*data_w-1:0] prod_t;

   // index of a word on the bus
   typedef logic [sel_w-1:0] sel_t;

endpackage

`default_nettype wire

// ==== design/muladd_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

// multiply / multiply-accumulate unit on the data flow bus
// flow_out trails flow_in and cfg by two cycles
module muladd_unit
   import muladd_types_pkg::*, muladd_config_pkg::*;
#(
   parameter int n_flow = 8   // words on the bus
) (
   input  wire logic               clk,
   input  wire logic               rst,
   input  wire muladd_cfg_t        cfg,
   input  wire data_t [n_flow-1:0] flow_in,
   output data_t                   flow_out
);

   operands_t  opnds;    // decode to execute
   muladd_op_e opcode;   // decode to result
   product_t   prod;     // execute to result

   muladd_decode #(
      .n_flow (n_flow)
   ) u_decode (
      .clk     (clk),
      .rst     (rst),
      .cfg     (cfg),
      .flow_in (flow_in),
      .opnds   (opnds),
      .opcode  (opcode)
   );

   muladd_execute u_execute (
      .clk   (clk),
      .rst   (rst),
      .opnds (opnds),
      .prod  (prod)
   );

   // opcode is static, so it needs no delay to meet its product
   muladd_result u_result (
      .clk      (clk),
      .rst      (rst),
      .prod     (prod),
      .opcode   (opcode),
      .flow_out (flow_out)
   );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# builds the muladd testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ns \
   --top-module muladd_tb -f versat_muladd.f -o muladd_sim

./obj_dir/muladd_sim | tee sim.log

# the simulator exit code is not trusted, the log decides
if grep -qx "test passed" sim.log; then
   echo "simulation ok"
   exit 0
else
   echo "simulation FAILED, see sim.log"
   exit 1
fi

// ==== tb/muladd_model.svh ====
`ifndef MULADD_MODEL_SVH
`define MULADD_MODEL_SVH

// expected results built from the opcode table of the unit

// full signed product of two flow words
function automatic prod_t signed_product(input data_t a, input data_t b);
   prod_t wide_a;
   prod_t wide_b;
   wide_a = {{data_w{a[data_w-1]}}, a};   // sign extend both
   wide_b = {{data_w{b[data_w-1]}}, b};
   return wide_a * wide_b;   // low 64 bits are exact
endfunction

// keeps the upper word, clears the lower
function automatic prod_t upper_only(input prod_t v);
   return {v[2*data_w-1 -: data_w], {data_w{1'b0}}};
endfunction

// next accumulator value for one product
function automatic prod_t shape_result(input muladd_op_e op, input prod_t p,
                                       input logic restart, input prod_t acc_prev);
   prod_t twice;     // q1.31 realignment
   prod_t low_up;    // low product word in the upper half
   prod_t mid_q16;   // bits 47..16 in the upper half
   prod_t result;
   twice   = p << 1;
   low_up  = {p[data_w-1:0], {data_w{1'b0}}};
   mid_q16 = {p[3*data_w/2-1 -: data_w], {data_w{1'b0}}};
   case (op)
      op_mul_div2:     result = upper_only(p);
      op_mul:          result = twice;
      op_mul_low:      result = low_up;
      op_mul_low_macc: result = acc_prev + low_up;   // zero in selo has no effect
      op_macc_div2:    result = restart ? upper_only(p) : upper_only(acc_prev + p);
      op_msub_div2:    result = restart ? p : acc_prev - p;
      op_macc_hi:      result = restart ? upper_only(twice) : upper_only(acc_prev + twice);
      op_macc_16q16:   result = restart ? mid_q16 : acc_prev + mid_q16;
      op_msub:         result = restart ? twice : acc_prev - twice;
      default:         result = restart ? twice : acc_prev + twice;
   endcase
   return result;
endfunction

// word that flow_out should carry
function automatic data_t expected_word(input prod_t shaped);
   return shaped[2*data_w-1 -: data_w];
endfunction

`endif

// ==== tb/muladd_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

// testbench for the multiply / multiply-accumulate unit
module muladd_tb
   import muladd_types_pkg::*, muladd_config_pkg::*;
();

   localparam int n_flow = 8;

   // how drive_sample treats the selo word
   localparam int any_word    = 0;
   localparam int nonzero_sel = 1;
   localparam int zero_sel    = 2;

   // one applied sample as the unit should see it
   typedef struct packed {
      logic  valid;
      data_t a;
      data_t b;
      logic  zero;   // selo word was zero
   } sample_t;

   logic               clk = 1'b0;
   logic               rst;
   muladd_cfg_t        cfg;
   data_t [n_flow-1:0] flow_in;
   data_t              flow_out;

   integer  seed;
   logic    drive_valid;
   sample_t cur;
   sample_t s1;   // two-deep history of samples
   sample_t s2;   // the one now on flow_out
   prod_t   m_acc;
   prod_t   exp_shaped;
   data_t   exp_out;

   int    sent = 0;
   int    checked = 0;
   int    rst_cycles = 0;
   int    flow_errs = 0;
   int    reset_errs = 0;
   int    timeouts = 0;
   int    errs_base = 0;
   int    tests_ok = 0;
   int    tests_bad = 0;
   string cur_test;

   `include "muladd_model.svh"

   muladd_unit #(
      .n_flow (n_flow)
   ) UUT (
      .clk      (clk),
      .rst      (rst),
      .cfg      (cfg),
      .flow_in  (flow_in),
      .flow_out (flow_out)
   );

   always #20 clk = ~clk;

   initial begin
      rst = 1'b1;
      repeat (16) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
   end

   // model pipeline mirrors the two register stages of the unit
   assign cur = {drive_valid, flow_in[cfg.sela], flow_in[cfg.selb], flow_in[cfg.selo] == '0};
   assign exp_shaped = shape_result(cfg.opcode, signed_product(s2.a, s2.b), s2.zero, m_acc);
   assign exp_out    = expected_word(exp_shaped);

   always @(posedge clk or posedge rst) begin
      if (rst) begin
         s1    <= '0;
         s2    <= '0;
         m_acc <= '0;
      end else begin
         s1    <= cur;
         s2    <= s1;
         m_acc <= exp_shaped;
         if (s2.valid) begin
            checked <= checked + 1;
         end
      end
   end

   always @(posedge clk) begin
      if (rst) begin
         rst_cycles <= rst_cycles + 1;
      end
   end

   flow_check_a: assert property (
      @(posedge clk) disable iff (rst)
         flow_out == exp_out
   ) else begin
      flow_errs++;
      $display("Error: %s expected %h actual %h", cur_test, $sampled(exp_out),
               $sampled(flow_out));
   end

   // registers settle a few cycles into reset
   reset_zero_a: assert property (
      @(posedge clk)
         (rst && rst_cycles > 2) |-> (flow_out == '0)
   ) else begin
      reset_errs++;
      $display("Error: %s expected %h actual %h", cur_test, 32'h0, $sampled(flow_out));
   end

   task automatic flag_timeout(input string what);
      timeouts++;
      $display("%s while running %s", what, cur_test);
   endtask

   task automatic wait_reset_release();
      int n;
      n = 0;
      while (rst && n < 40) begin
         @(negedge clk);
         n++;
      end
      if (rst) begin
         flag_timeout("reset still high after 40 cycles");
      end
   endtask

   // stops driving and waits until every sample has been checked
   task automatic wait_settled();
      int n;
      @(negedge clk);
      drive_valid = 1'b0;
      n = 0;
      while (checked != sent && n < 10) begin
         @(negedge clk);
         n++;
      end
      if (checked != sent) begin
         flag_timeout("pipeline did not drain within 10 cycles");
      end
   endtask

   task automatic set_cfg(input int a, input int b, input int o, input muladd_op_e op);
      cfg.sela   = sel_t'(a);
      cfg.selb   = sel_t'(b);
      cfg.selo   = sel_t'(o);
      cfg.opcode = op;
   endtask

   task automatic drive_sample(input int mode);
      data_t [n_flow-1:0] words;
      int i;
      @(negedge clk);
      for (i = 0; i < n_flow; i++) begin
         words[i] = $random(seed);
      end
      if (mode == nonzero_sel && words[cfg.selo] == '0) begin
         words[cfg.selo] = 32'h1;
      end
      if (mode == zero_sel) begin
         words[cfg.selo] = '0;
      end
      flow_in     = words;
      drive_valid = 1'b1;
      sent++;
   endtask

   task automatic run_samples(input int count, input int mode);
      int i;
      for (i = 0; i < count; i++) begin
         drive_sample(mode);
      end
   endtask

   task automatic start_test(input string name);
      cur_test  = name;
      errs_base = flow_errs + reset_errs + timeouts;
   endtask

   task automatic report_test();
      int errs;
      errs = flow_errs + reset_errs + timeouts - errs_base;
      if (errs == 0) begin
         tests_ok++;
         $display("%-16s ok", cur_test);
      end else begin
         tests_bad++;
         $display("%-16s %0d errors", cur_test, errs);
      end
   endtask

   task automatic plain_case(input string name, input muladd_op_e op);
      start_test(name);
      set_cfg(3, 5, 6, op);
      run_samples(12, any_word);
      wait_settled();
      report_test();
   endtask

   task automatic accumulate_case(input string name, input muladd_op_e op);
      start_test(name);
      set_cfg(1, 4, 7, op);
      run_samples(20, nonzero_sel);
      wait_settled();
      report_test();
   endtask

   // one zero in the middle of a run
   task automatic restart_case(input string name, input muladd_op_e op);
      start_test(name);
      set_cfg(2, 6, 0, op);
      run_samples(5, nonzero_sel);
      run_samples(1, zero_sel);
      run_samples(5, nonzero_sel);
      wait_settled();
      report_test();
   endtask

   task automatic routing_sweep();
      int i;
      start_test("routing");
      for (i = 0; i < n_flow; i++) begin
         set_cfg(i, n_flow - 1 - i, (i + 3) % n_flow, op_macc);
         run_samples(2, nonzero_sel);
         run_samples(1, zero_sel);   // shows up only if selo picks the right word
         run_samples(1, nonzero_sel);
         wait_settled();
      end
      report_test();
   endtask

   initial begin
      seed        = 91;
      cfg         = '0;
      flow_in     = '0;
      drive_valid = 1'b0;

      start_test("reset");
      wait_reset_release();
      set_cfg(0, 1, 2, op_macc);
      run_samples(4, nonzero_sel);
      wait_settled();
      report_test();

      plain_case("mul", op_mul);
      plain_case("mul_div2", op_mul_div2);
      plain_case("mul_low", op_mul_low);

      accumulate_case("macc", op_macc);
      accumulate_case("macc_hi", op_macc_hi);
      accumulate_case("macc_div2", op_macc_div2);
      accumulate_case("macc_16q16", op_macc_16q16);
      accumulate_case("msub", op_msub);
      accumulate_case("msub_div2", op_msub_div2);

      restart_case("restart_macc", op_macc);
      restart_case("restart_macc_hi", op_macc_hi);
      restart_case("restart_div2", op_macc_div2);
      restart_case("restart_msub", op_msub);
      restart_case("restart_msub2", op_msub_div2);
      restart_case("restart_16q16", op_macc_16q16);
      restart_case("restart_lowmacc", op_mul_low_macc);

      routing_sweep();

      $display("tests %0d, ok %0d, failing %0d", tests_ok + tests_bad, tests_ok, tests_bad);
      if (tests_bad == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== versat_muladd.f ====
+incdir+tb
design/muladd_types_pkg.sv
design/muladd_config_pkg.sv
design/muladd_decode.sv
design/muladd_execute.sv
design/muladd_result.sv
design/muladd_unit.sv
tb/muladd_tb.sv
